/* issue_core.f */
+incdir+verif
common/issue_pkg.sv
hdl/rename_table.sv
hdl/tag_allocator.sv
reservation_station/reservation_station.sv
hdl/alu_pipe.sv
hdl/issue_core.sv
verif/issue_core_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f issue_core.f --top-module issue_core_tb -o issue_core_sim &&
    ./obj_dir/issue_core_sim | tee /dev/stderr | grep -q "All tests passed" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

/* verif/issue_model.svh */
// program-order reference state
logic [data_width-1:0] model_regs [reg_count];
logic [data_width-1:0] exp_value [256];
logic [tag_width-1:0]  exp_tag [256];
bit                    exp_outstanding [256];
bit                    model_tag_busy [1 << tag_width];
int                    model_seq;
int                    outstanding_count;

task automatic model_reset();
    for (int i = 0; i < reg_count; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        exp_outstanding[i] = 1'b0;
    end
    for (int i = 0; i < (1 << tag_width); i++) begin
        model_tag_busy[i] = 1'b0;
    end
    model_seq         = 0;
    outstanding_count = 0;
endtask

// apply one accepted dispatch and remember its result by sequence number
task automatic record_dispatch(op_t o, int d, int s1, int s2, logic [data_width-1:0] value);
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] result;
    int                    tag;
    a = model_regs[s1];
    b = model_regs[s2];
    case (o)
        op_add:  result = a + b;
        op_sub:  result = a - b;
        op_xor:  result = a ^ b;
        default: result = a + value;
    endcase
    // r0 stays zero
    if (d != 0) begin
        model_regs[d] = result;
    end
    // tags are handed out lowest first from 1
    tag = 0;
    for (int t = 1; t < (1 << tag_width); t++) begin
        if (tag == 0 && !model_tag_busy[t]) begin
            tag = t;
        end
    end
    if (tag != 0) begin
        model_tag_busy[tag] = 1'b1;
    end
    exp_tag[model_seq]         = tag_width'(tag);
    exp_value[model_seq]       = result;
    exp_outstanding[model_seq] = 1'b1;
    outstanding_count++;
    model_seq = (model_seq + 1) % 256;
endtask

/* verif/issue_core_tb.sv */
module issue_core_tb import issue_pkg::*; ();

    localparam int wait_limit = 200;

    logic                      clk;
    logic                      reset;
    logic                      dispatch;
    op_t                       op;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [data_width-1:0]     imm;
    logic                      stall;
    logic                      cdb_valid;
    logic [tag_width-1:0]      cdb_tag;
    logic [data_width-1:0]     cdb_value;
    logic [birthday_width-1:0] cdb_seq;

    int errors;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int broadcasts;
    int accepted;

    `include "issue_model.svh"

    issue_core issue_core_inst (
        .clk       (clk),
        .reset     (reset),
        .dispatch  (dispatch),
        .op        (op),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2),
        .imm       (imm),
        .stall     (stall),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value),
        .cdb_seq   (cdb_seq)
    );

    always #50 clk = ~clk;

    task automatic check(string name, logic [data_width-1:0] actual,
                         logic [data_width-1:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_failure(string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(string name);
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
        test_errors = errors;
    endtask

    // CDB monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && cdb_valid) begin
            broadcasts++;
            if (!exp_outstanding[cdb_seq]) begin
                report_failure($sformatf("broadcast for sequence %0d with no open dispatch",
                                         cdb_seq));
            end else begin
                check("cdb_value", cdb_value, exp_value[cdb_seq]);
                check("cdb_tag", data_width'(cdb_tag), data_width'(exp_tag[cdb_seq]));
                model_tag_busy[exp_tag[cdb_seq]] = 1'b0;
                exp_outstanding[cdb_seq] = 1'b0;
                outstanding_count--;
            end
        end
    end

    // drive one instruction for one cycle and report whether stall let it in
    task automatic offer(op_t o, int d, int s1, int s2, logic [data_width-1:0] value,
                         output bit taken);
        dispatch = 1'b1;
        op       = o;
        rd       = reg_addr_width'(d);
        rs1      = reg_addr_width'(s1);
        rs2      = reg_addr_width'(s2);
        imm      = value;
        taken    = !stall;
        if (taken) begin
            record_dispatch(o, d, s1, s2, value);
            accepted++;
        end
        @(posedge clk);
        #10;
        dispatch = 1'b0;
    endtask

    task automatic wait_for_stall_low();
        int n;
        n = 0;
        while (stall && n < wait_limit) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (stall) begin
            report_failure("stall stayed high past the timeout");
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (outstanding_count != 0 && n < wait_limit) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (outstanding_count != 0) begin
            report_failure($sformatf("%0d dispatches never broadcast", outstanding_count));
        end
    endtask

    // random program of count instructions over registers lo to hi
    task automatic run_program(int count, int dst_lo, int dst_hi, int src_lo, int src_hi);
        bit                    taken;
        int                    tries;
        op_t                   o;
        int                    d;
        int                    s1;
        int                    s2;
        logic [data_width-1:0] value;
        for (int i = 0; i < count; i++) begin
            o     = op_t'($urandom_range(3, 0));
            d     = int'($urandom_range(dst_hi, dst_lo));
            s1    = int'($urandom_range(src_hi, src_lo));
            s2    = int'($urandom_range(src_hi, src_lo));
            value = $urandom();
            taken = 1'b0;
            tries = 0;
            // offers made under stall are dropped and repeated
            while (!taken && tries < wait_limit) begin
                offer(o, d, s1, s2, value, taken);
                tries++;
            end
            if (!taken) begin
                report_failure("instruction was not accepted before the timeout");
            end
        end
        drain();
    endtask

    initial begin
        bit taken;
        int n;
        int chain_taken;
        int under_stall;
        void'($urandom(32'h45a52845));
        clk          = 1'b0;
        reset        = 1'b1;
        dispatch     = 1'b0;
        op           = op_add;
        rd           = '0;
        rs1          = '0;
        rs2          = '0;
        imm          = '0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        broadcasts   = 0;
        accepted     = 0;
        model_reset();
        repeat (10) @(posedge clk);
        #10;
        reset = 1'b0;

        check("stall", data_width'(stall), '0);
        check("cdb_valid", data_width'(cdb_valid), '0);
        finish_test("reset state");

        offer(op_addi, 1, 0, 0, $urandom(), taken);
        if (!taken) begin
            report_failure("single addi was not accepted by an idle core");
        end
        n = 0;
        while (n < wait_limit) begin
            @(negedge clk);
            n++;
            if (cdb_valid) begin
                break;
            end
        end
        check("cdb latency", data_width'(n), data_width'(3));
        drain();
        finish_test("single addi latency");

        // source registers get values before the program reads them
        for (int r = 1; r < 8; r++) begin
            wait_for_stall_low();
            offer(op_addi, r, 0, 0, $urandom(), taken);
        end
        drain();
        run_program(200, 8, 15, 1, 7);
        finish_test("independent program");

        run_program(300, 1, 4, 1, 4);
        finish_test("dependent program");

        check("broadcast count", data_width'(broadcasts), data_width'(accepted));
        check("outstanding", data_width'(outstanding_count), '0);
        check("stall", data_width'(stall), '0);
        finish_test("completeness");

        // chain through r5 keeps every new entry waiting on the previous one
        chain_taken = 0;
        under_stall = 0;
        n = 0;
        while (chain_taken < 24 && n < 4 * wait_limit) begin
            offer(op_t'($urandom_range(3, 0)), 5, 5, 6, $urandom(), taken);
            if (taken) begin
                chain_taken++;
            end else begin
                under_stall++;
            end
            n++;
        end
        if (chain_taken < 24) begin
            report_failure("dependent chain could not be dispatched in time");
        end
        if (under_stall == 0) begin
            report_failure("stall never rose while the station filled");
        end
        drain();
        wait_for_stall_low();
        check("broadcast count", data_width'(broadcasts), data_width'(accepted));
        finish_test("saturation");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* hdl/issue_core.sv */
module issue_core import issue_pkg::*; #(
    parameter int rs_depth = 4,
    parameter int num_tags = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dispatch,
    input  op_t                       op,
    input  logic [reg_addr_width-1:0] rd,
    input  logic [reg_addr_width-1:0] rs1,
    input  logic [reg_addr_width-1:0] rs2,
    input  logic [data_width-1:0]     imm,
    output logic                      stall,
    output logic                      cdb_valid,
    output logic [tag_width-1:0]      cdb_tag,
    output logic [data_width-1:0]     cdb_value,
    output logic [birthday_width-1:0] cdb_seq
);

    logic                      dispatch_fire;
    logic                      rs_full;
    logic                      tag_empty;
    logic [tag_width-1:0]      alloc_tag;
    logic [data_width-1:0]     rs1_value;
    logic [tag_width-1:0]      rs1_tag;
    logic                      rs1_ready;
    logic [data_width-1:0]     rs2_value;
    logic [tag_width-1:0]      rs2_tag;
    logic                      rs2_ready;
    logic                      issue_valid;
    op_t                       issue_op;
    logic [data_width-1:0]     issue_a;
    logic [data_width-1:0]     issue_b;
    logic [tag_width-1:0]      issue_tag;
    logic [birthday_width-1:0] issue_seq;

    // a dispatch under stall is dropped
    assign stall         = rs_full || tag_empty;
    assign dispatch_fire = dispatch && !stall;

    rename_table rename_table_inst (
        .clk           (clk),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .new_tag       (alloc_tag),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .rs1_value     (rs1_value),
        .rs1_tag       (rs1_tag),
        .rs1_ready     (rs1_ready),
        .rs2_value     (rs2_value),
        .rs2_tag       (rs2_tag),
        .rs2_ready     (rs2_ready)
    );

    tag_allocator #(
        .num_tags (num_tags)
    ) tag_allocator_inst (
        .clk           (clk),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .alloc_tag     (alloc_tag),
        .tag_empty     (tag_empty)
    );

    reservation_station #(
        .rs_depth (rs_depth)
    ) reservation_station_inst (
        .clk           (clk),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .op            (op),
        .imm           (imm),
        .new_tag       (alloc_tag),
        .rs1_value     (rs1_value),
        .rs1_tag       (rs1_tag),
        .rs1_ready     (rs1_ready),
        .rs2_value     (rs2_value),
        .rs2_tag       (rs2_tag),
        .rs2_ready     (rs2_ready),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .rs_full       (rs_full),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_tag     (issue_tag),
        .issue_seq     (issue_seq)
    );

    alu_pipe alu_pipe_inst (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_a     (issue_a),
        .issue_b     (issue_b),
        .issue_tag   (issue_tag),
        .issue_seq   (issue_seq),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .cdb_seq     (cdb_seq)
    );

endmodule

/* hdl/alu_pipe.sv */
module alu_pipe import issue_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  op_t                       issue_op,
    input  logic [data_width-1:0]     issue_a,
    input  logic [data_width-1:0]     issue_b,
    input  logic [tag_width-1:0]      issue_tag,
    input  logic [birthday_width-1:0] issue_seq,
    output logic                      cdb_valid,
    output logic [tag_width-1:0]      cdb_tag,
    output logic [data_width-1:0]     cdb_value,
    output logic [birthday_width-1:0] cdb_seq
);

    logic [alu_latency-1:0]    stage_valid;
    op_t                       s1_op;
    logic [data_width-1:0]     s1_a;
    logic [data_width-1:0]     s1_b;
    logic [tag_width-1:0]      s1_tag;
    logic [birthday_width-1:0] s1_seq;
    logic [data_width-1:0]     s1_result;

    always_comb begin
        case (s1_op)
            op_sub:  s1_result = s1_a - s1_b;
            op_xor:  s1_result = s1_a ^ s1_b;
            // b already carries the immediate for addi
            default: s1_result = s1_a + s1_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid <= {stage_valid[alu_latency-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        s1_op     <= issue_op;
        s1_a      <= issue_a;
        s1_b      <= issue_b;
        s1_tag    <= issue_tag;
        s1_seq    <= issue_seq;
        cdb_value <= s1_result;
        cdb_tag   <= s1_tag;
        cdb_seq   <= s1_seq;
    end

    assign cdb_valid = stage_valid[alu_latency-1];

endmodule

/* reservation_station/reservation_station.sv */
module reservation_station import issue_pkg::*; #(
    parameter int rs_depth = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  op_t                       op,
    input  logic [data_width-1:0]     imm,
    input  logic [tag_width-1:0]      new_tag,
    input  logic [data_width-1:0]     rs1_value,
    input  logic [tag_width-1:0]      rs1_tag,
    input  logic                      rs1_ready,
    input  logic [data_width-1:0]     rs2_value,
    input  logic [tag_width-1:0]      rs2_tag,
    input  logic                      rs2_ready,
    input  logic                      cdb_valid,
    input  logic [tag_width-1:0]      cdb_tag,
    input  logic [data_width-1:0]     cdb_value,
    output logic                      rs_full,
    output logic                      issue_valid,
    output op_t                       issue_op,
    output logic [data_width-1:0]     issue_a,
    output logic [data_width-1:0]     issue_b,
    output logic [tag_width-1:0]      issue_tag,
    output logic [birthday_width-1:0] issue_seq
);

    localparam int idx_width = $clog2(rs_depth);

    logic [rs_depth-1:0]       entry_valid;
    op_t                       entry_op       [rs_depth];
    logic [data_width-1:0]     entry_a_value  [rs_depth];
    logic [tag_width-1:0]      entry_a_tag    [rs_depth];
    logic                      entry_a_ready  [rs_depth];
    logic [data_width-1:0]     entry_b_value  [rs_depth];
    logic [tag_width-1:0]      entry_b_tag    [rs_depth];
    logic                      entry_b_ready  [rs_depth];
    logic [tag_width-1:0]      entry_dst_tag  [rs_depth];
    logic [birthday_width-1:0] entry_birthday [rs_depth];
    logic [birthday_width-1:0] entry_age      [rs_depth];
    logic [birthday_width-1:0] birth_count;
    logic [birthday_width-1:0] best_age;
    logic [idx_width-1:0]      sel_idx;
    logic                      sel_found;
    logic [idx_width-1:0]      free_idx;
    logic                      free_found;

    // distance from the counter keeps ordering across the wrap
    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            entry_age[i] = birth_count - entry_birthday[i];
        end
    end

    // oldest entry with both operands in hand
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        best_age  = '0;
        for (int i = 0; i < rs_depth; i++) begin
            if (entry_valid[i] && entry_a_ready[i] && entry_b_ready[i] &&
                    (!sel_found || (entry_age[i] > best_age))) begin
                sel_found = 1'b1;
                sel_idx   = idx_width'(i);
                best_age  = entry_age[i];
            end
        end
    end

    // lowest free slot
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_found = 1'b1;
                free_idx   = idx_width'(i);
            end
        end
    end

    assign rs_full     = !free_found;
    assign issue_valid = sel_found;
    assign issue_op    = entry_op[sel_idx];
    assign issue_a     = entry_a_value[sel_idx];
    assign issue_b     = entry_b_value[sel_idx];
    assign issue_tag   = entry_dst_tag[sel_idx];
    assign issue_seq   = entry_birthday[sel_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
            birth_count <= '0;
        end else begin
            if (sel_found) begin
                entry_valid[sel_idx] <= 1'b0;
            end
            if (dispatch_fire) begin
                entry_valid[free_idx] <= 1'b1;
                birth_count           <= birth_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (dispatch_fire && (free_idx == idx_width'(i))) begin
                entry_op[i]       <= op;
                entry_a_value[i]  <= rs1_value;
                entry_a_tag[i]    <= rs1_tag;
                entry_a_ready[i]  <= rs1_ready;
                entry_dst_tag[i]  <= new_tag;
                entry_birthday[i] <= birth_count;
                if (op == op_addi) begin
                    entry_b_value[i] <= imm;
                    entry_b_tag[i]   <= no_tag;
                    entry_b_ready[i] <= 1'b1;
                end else begin
                    entry_b_value[i] <= rs2_value;
                    entry_b_tag[i]   <= rs2_tag;
                    entry_b_ready[i] <= rs2_ready;
                end
            end else if (cdb_valid) begin
                // snoop the broadcast for waiting operands
                if (!entry_a_ready[i] && (entry_a_tag[i] == cdb_tag)) begin
                    entry_a_value[i] <= cdb_value;
                    entry_a_ready[i] <= 1'b1;
                end
                if (!entry_b_ready[i] && (entry_b_tag[i] == cdb_tag)) begin
                    entry_b_value[i] <= cdb_value;
                    entry_b_ready[i] <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/tag_allocator.sv */
module tag_allocator import issue_pkg::*; #(
    parameter int num_tags = 8
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_fire,
    input  logic                 cdb_valid,
    input  logic [tag_width-1:0] cdb_tag,
    output logic [tag_width-1:0] alloc_tag,
    output logic                 tag_empty
);

    // tag 0 is never handed out
    logic [num_tags-1:1] busy;

    // scan downward so the lowest free tag is the one left
    always_comb begin
        alloc_tag = no_tag;
        tag_empty = 1'b1;
        for (int i = num_tags - 1; i >= 1; i--) begin
            if (!busy[i]) begin
                alloc_tag = tag_width'(i);
                tag_empty = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (cdb_valid && (cdb_tag != no_tag)) begin
                busy[cdb_tag] <= 1'b0;
            end
            // offered tag is free, so it never collides with the freed one
            if (dispatch_fire) begin
                busy[alloc_tag] <= 1'b1;
            end
        end
    end

endmodule

/* hdl/rename_table.sv */
module rename_table import issue_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      dispatch_fire,
    input  logic [reg_addr_width-1:0] rd,
    input  logic [reg_addr_width-1:0] rs1,
    input  logic [reg_addr_width-1:0] rs2,
    input  logic [tag_width-1:0]      new_tag,
    input  logic                      cdb_valid,
    input  logic [tag_width-1:0]      cdb_tag,
    input  logic [data_width-1:0]     cdb_value,
    output logic [data_width-1:0]     rs1_value,
    output logic [tag_width-1:0]      rs1_tag,
    output logic                      rs1_ready,
    output logic [data_width-1:0]     rs2_value,
    output logic [tag_width-1:0]      rs2_tag,
    output logic                      rs2_ready
);

    logic [data_width-1:0] reg_value   [reg_count];
    logic [tag_width-1:0]  reg_tag     [reg_count];
    logic                  reg_pending [reg_count];
    logic                  rs1_hit;
    logic                  rs2_hit;

    // a producer finishing this cycle counts as ready
    assign rs1_hit = reg_pending[rs1] && cdb_valid && (cdb_tag == reg_tag[rs1]);
    assign rs2_hit = reg_pending[rs2] && cdb_valid && (cdb_tag == reg_tag[rs2]);

    assign rs1_value = rs1_hit ? cdb_value : reg_value[rs1];
    assign rs1_tag   = reg_tag[rs1];
    assign rs1_ready = !reg_pending[rs1] || rs1_hit;

    assign rs2_value = rs2_hit ? cdb_value : reg_value[rs2];
    assign rs2_tag   = reg_tag[rs2];
    assign rs2_ready = !reg_pending[rs2] || rs2_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                reg_value[i]   <= '0;
                reg_tag[i]     <= no_tag;
                reg_pending[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < reg_count; i++) begin
                if (cdb_valid && reg_pending[i] && (reg_tag[i] == cdb_tag)) begin
                    reg_value[i]   <= cdb_value;
                    reg_pending[i] <= 1'b0;
                end
                // newer rename wins over the writeback
                if (dispatch_fire && (rd == reg_addr_width'(i)) && (i != 0)) begin
                    reg_tag[i]     <= new_tag;
                    reg_pending[i] <= 1'b1;
                end
            end
        end
    end

endmodule

/* common/issue_pkg.sv */
package issue_pkg;

    // operand and result width
    localparam int data_width = 32;

    // architectural register file
    localparam int reg_count = 16;
    localparam int reg_addr_width = 4;

    // result tags, tag 0 means no pending producer
    localparam int tag_width = 3;
    localparam logic [tag_width-1:0] no_tag = '0;

    // dispatch sequence number
    localparam int birthday_width = 8;

    // stages in the ALU pipe
    localparam int alu_latency = 2;

    typedef enum logic [1:0] {
        op_add  = 2'd0,
        op_sub  = 2'd1,
        op_xor  = 2'd2,
        // second source is replaced by the immediate
        op_addi = 2'd3
    } op_t;

endpackage
